//--- rtl/mq_pkg.sv
package mq_pkg;

  // Queue numbering
  localparam int NUMQ = 4;
  localparam int BITQ = 2;

  // Shared buffer
  localparam int NUMADDR = 16;
  localparam int BITADDR = 4;
  localparam int BITCNT = 5;  // Holds 0 to NUMADDR

  localparam int WIDTH = 16;

  typedef enum logic {
    FL_INIT,  // Loading pointers after reset
    FL_RUN
  } fl_state_t;

endpackage

//--- rtl/mq_mem_if.sv
`timescale 1ns/10ps

interface mq_mem_if;

  logic                        wr_en;
  logic [mq_pkg::BITADDR-1:0]  wr_ptr;
  logic [mq_pkg::WIDTH-1:0]    wr_data;
  logic                        rd_en;
  logic [mq_pkg::BITADDR-1:0]  rd_ptr;

  // Queue control side
  modport ctrl (output wr_en, output wr_ptr, output wr_data, output rd_en, output rd_ptr);

  // Data memory side
  modport data (input wr_en, input wr_ptr, input wr_data, input rd_en, input rd_ptr);

endinterface

//--- rtl/mq_free_list.sv
`timescale 1ns/10ps

module mq_free_list (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        alloc,
  output logic [mq_pkg::BITADDR-1:0]  alloc_ptr,
  input  logic                        release_en,
  input  logic [mq_pkg::BITADDR-1:0]  release_ptr,
  output logic                        full,
  output logic                        ready
);

  mq_pkg::fl_state_t           state;
  logic [mq_pkg::BITADDR-1:0]  stack [mq_pkg::NUMADDR];
  logic [mq_pkg::BITCNT-1:0]   depth;  // Free pointers held
  logic [mq_pkg::BITADDR-1:0]  init_ptr;
  logic [mq_pkg::BITADDR-1:0]  top;

  assign top = depth[mq_pkg::BITADDR-1:0] - 1'b1;  // Wraps to last slot when depth is NUMADDR
  assign alloc_ptr = stack[top];
  assign ready = (state == mq_pkg::FL_RUN);
  assign full = ready && (depth == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mq_pkg::FL_INIT;
      depth <= '0;
      init_ptr <= '0;
    end else if (state == mq_pkg::FL_INIT) begin
      init_ptr <= init_ptr + 1'b1;
      depth <= depth + 1'b1;
      if (&init_ptr) begin  // Last pointer loaded
        state <= mq_pkg::FL_RUN;
      end
    end else begin
      case ({alloc, release_en})
        2'b10:   depth <= depth - 1'b1;
        2'b01:   depth <= depth + 1'b1;
        default: depth <= depth;  // Swap keeps the depth
      endcase
    end
  end

  // Stack contents
  always_ff @(posedge clk) begin
    if (state == mq_pkg::FL_INIT) begin
      stack[init_ptr] <= init_ptr;
    end else if (alloc && release_en) begin
      stack[top] <= release_ptr;  // Replace the popped top
    end else if (release_en) begin
      stack[depth[mq_pkg::BITADDR-1:0]] <= release_ptr;
    end
  end

endmodule

//--- rtl/mq_queue_ctrl.sv
`timescale 1ns/10ps

module mq_queue_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  logic [mq_pkg::BITQ-1:0]     pu_prt,
  input  logic [mq_pkg::WIDTH-1:0]    pu_din,
  input  logic                        pop,
  input  logic [mq_pkg::BITQ-1:0]     po_prt,
  input  logic                        cp_read,
  input  logic [mq_pkg::BITQ-1:0]     cp_adr,
  input  logic                        ready,
  input  logic                        full,
  input  logic [mq_pkg::BITADDR-1:0]  alloc_ptr,
  output logic                        alloc,
  output logic                        release_en,
  output logic [mq_pkg::BITADDR-1:0]  release_ptr,
  mq_mem_if.ctrl                      mem,
  output logic                        cp_vld,
  output logic [mq_pkg::BITCNT-1:0]   cp_dout
);

  logic [mq_pkg::BITADDR-1:0]  head [mq_pkg::NUMQ];
  logic [mq_pkg::BITADDR-1:0]  tail [mq_pkg::NUMQ];
  logic [mq_pkg::BITCNT-1:0]   cnt [mq_pkg::NUMQ];
  logic [mq_pkg::BITCNT-1:0]   cnt_nxt [mq_pkg::NUMQ];
  logic [mq_pkg::BITADDR-1:0]  link [mq_pkg::NUMADDR];  // Next entry of each chain

  logic                        pu_acc;
  logic                        po_acc;
  logic                        pu_first;
  logic                        po_handoff;

  logic                        wr_en_q;
  logic [mq_pkg::BITADDR-1:0]  wr_ptr_q;
  logic [mq_pkg::WIDTH-1:0]    wr_data_q;
  logic                        rd_en_q;
  logic [mq_pkg::BITADDR-1:0]  rd_ptr_q;
  logic                        cp_vld_q;
  logic [mq_pkg::BITCNT-1:0]   cp_cnt_q;

  assign pu_acc = push && ready && !full;
  assign po_acc = pop && ready && (cnt[po_prt] != '0);
  assign pu_first = (cnt[pu_prt] == '0);
  // Last entry popped while a push lands on the same queue
  assign po_handoff = pu_acc && (pu_prt == po_prt) && (head[po_prt] == tail[po_prt]);

  assign alloc = pu_acc;
  assign release_en = po_acc;
  assign release_ptr = head[po_prt];

  always_comb begin
    cnt_nxt = cnt;
    if (pu_acc) begin
      cnt_nxt[pu_prt] = cnt_nxt[pu_prt] + 1'b1;
    end
    if (po_acc) begin
      cnt_nxt[po_prt] = cnt_nxt[po_prt] - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '{default: '0};
    end else begin
      cnt <= cnt_nxt;
    end
  end

  // Pointers only meaningful while the count is nonzero
  always_ff @(posedge clk) begin
    if (pu_acc) begin
      tail[pu_prt] <= alloc_ptr;
      if (pu_first) begin
        head[pu_prt] <= alloc_ptr;
      end else begin
        link[tail[pu_prt]] <= alloc_ptr;
      end
    end
    if (po_acc) begin
      head[po_prt] <= po_handoff ? alloc_ptr : link[head[po_prt]];
    end
  end

  // Two stage operation pipe toward the data stage and CPU port
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_q <= 1'b0;
      rd_en_q <= 1'b0;
      cp_vld_q <= 1'b0;
      mem.wr_en <= 1'b0;
      mem.rd_en <= 1'b0;
      cp_vld <= 1'b0;
    end else begin
      wr_en_q <= pu_acc;
      rd_en_q <= po_acc;
      cp_vld_q <= cp_read;
      mem.wr_en <= wr_en_q;
      mem.rd_en <= rd_en_q;
      cp_vld <= cp_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    wr_ptr_q <= alloc_ptr;
    wr_data_q <= pu_din;
    rd_ptr_q <= head[po_prt];
    cp_cnt_q <= cnt[cp_adr];  // Count before this edge's update
    mem.wr_ptr <= wr_ptr_q;
    mem.wr_data <= wr_data_q;
    mem.rd_ptr <= rd_ptr_q;
    cp_dout <= cp_cnt_q;
  end

endmodule

//--- rtl/mq_data_stage.sv
`timescale 1ns/10ps

module mq_data_stage (
  input  logic                      clk,
  input  logic                      rst,
  mq_mem_if.data                    mem,
  output logic                      po_vld,
  output logic [mq_pkg::WIDTH-1:0]  po_dout
);

  logic [mq_pkg::WIDTH-1:0] ram [mq_pkg::NUMADDR];

  // Write and read share the edge; a read never targets the entry written here
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      ram[mem.wr_ptr] <= mem.wr_data;
    end
    if (mem.rd_en) begin
      po_dout <= ram[mem.rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      po_vld <= 1'b0;
    end else begin
      po_vld <= mem.rd_en;  // One cycle strobe
    end
  end

endmodule

//--- rtl/mq_top.sv
`timescale 1ns/10ps

module mq_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  logic [mq_pkg::BITQ-1:0]     pu_prt,
  input  logic [mq_pkg::WIDTH-1:0]    pu_din,
  input  logic                        pop,
  input  logic [mq_pkg::BITQ-1:0]     po_prt,
  input  logic                        cp_read,
  input  logic [mq_pkg::BITQ-1:0]     cp_adr,
  output logic                        ready,
  output logic                        full,
  output logic                        po_vld,
  output logic [mq_pkg::WIDTH-1:0]    po_dout,
  output logic                        cp_vld,
  output logic [mq_pkg::BITCNT-1:0]   cp_dout
);

  logic                        alloc;
  logic [mq_pkg::BITADDR-1:0]  alloc_ptr;
  logic                        release_en;
  logic [mq_pkg::BITADDR-1:0]  release_ptr;

  mq_mem_if mem ();

  mq_free_list u_free_list (
    .clk         (clk),
    .rst         (rst),
    .alloc       (alloc),
    .alloc_ptr   (alloc_ptr),
    .release_en  (release_en),
    .release_ptr (release_ptr),
    .full        (full),
    .ready       (ready)
  );

  mq_queue_ctrl u_queue_ctrl (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .pu_prt      (pu_prt),
    .pu_din      (pu_din),
    .pop         (pop),
    .po_prt      (po_prt),
    .cp_read     (cp_read),
    .cp_adr      (cp_adr),
    .ready       (ready),
    .full        (full),
    .alloc_ptr   (alloc_ptr),
    .alloc       (alloc),
    .release_en  (release_en),
    .release_ptr (release_ptr),
    .mem         (mem.ctrl),
    .cp_vld      (cp_vld),
    .cp_dout     (cp_dout)
  );

  mq_data_stage u_data_stage (
    .clk     (clk),
    .rst     (rst),
    .mem     (mem.data),
    .po_vld  (po_vld),
    .po_dout (po_dout)
  );

endmodule

//--- test/mq_assertions.sv
`timescale 1ns/10ps

module mq_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       ready,
  input logic                       full,
  input logic                       pop,
  input logic [mq_pkg::BITQ-1:0]    po_prt,
  input logic [mq_pkg::BITCNT-1:0]  cnt [mq_pkg::NUMQ]
);

  int cnt_sum;

  always_comb begin
    cnt_sum = 0;
    for (int i = 0; i < mq_pkg::NUMQ; i++) begin
      cnt_sum = cnt_sum + int'(cnt[i]);
    end
  end

  // An empty queue only grows through a push
  pop_not_empty: assert property (@(posedge clk) disable iff (rst || !ready)
    (pop && cnt[po_prt] == '0) |=> (cnt[$past(po_prt)] <= mq_pkg::BITCNT'(1)))
    else $error("pop of an empty queue underflowed its count");

  occupancy_limit: assert property (@(posedge clk) disable iff (rst || !ready)
    cnt_sum <= mq_pkg::NUMADDR)
    else $error("queue counts add up to %0d, above the buffer size", cnt_sum);

  // Buffer exhausted
  full_blocks_push: assert property (@(posedge clk) disable iff (rst || !ready)
    full |=> (cnt_sum <= $past(cnt_sum)))
    else $error("queue counts grew while the buffer was full");

endmodule

bind mq_queue_ctrl mq_assertions u_assertions (
  .clk    (clk),
  .rst    (rst),
  .ready  (ready),
  .full   (full),
  .pop    (pop),
  .po_prt (po_prt),
  .cnt    (cnt)
);

//--- test/mq_tb.sv
`timescale 1ns/10ps

module mq_tb;

  typedef struct packed {
    logic                       push;
    logic [mq_pkg::BITQ-1:0]    pu_prt;
    logic                       pop;
    logic [mq_pkg::BITQ-1:0]    po_prt;
    logic                       po_ok;  // Pop expected to be accepted
    logic                       cp_read;
    logic [mq_pkg::BITQ-1:0]    cp_adr;
    logic [mq_pkg::BITCNT-1:0]  cp_cnt;
  } row_t;

  logic                       clk;
  logic                       rst;
  logic                       push;
  logic [mq_pkg::BITQ-1:0]    pu_prt;
  logic [mq_pkg::WIDTH-1:0]   pu_din;
  logic                       pop;
  logic [mq_pkg::BITQ-1:0]    po_prt;
  logic                       cp_read;
  logic [mq_pkg::BITQ-1:0]    cp_adr;
  logic                       ready;
  logic                       full;
  logic                       po_vld;
  logic [mq_pkg::WIDTH-1:0]   po_dout;
  logic                       cp_vld;
  logic [mq_pkg::BITCNT-1:0]  cp_dout;

  row_t                      table_q [$];
  logic [mq_pkg::WIDTH-1:0]  lfsr;
  int                        cyc;  // Rising edges seen so far

  // Reference queues as circular buffers
  logic [mq_pkg::WIDTH-1:0]  model_mem [mq_pkg::NUMQ][mq_pkg::NUMADDR];
  int                        model_rd [mq_pkg::NUMQ];
  int                        model_cnt [mq_pkg::NUMQ];
  int                        model_total;

  int                        po_due [$];
  logic [mq_pkg::WIDTH-1:0]  po_exp [$];
  int                        cp_due [$];
  int                        cp_exp [$];

  mq_top DUT (
    .clk     (clk),
    .rst     (rst),
    .push    (push),
    .pu_prt  (pu_prt),
    .pu_din  (pu_din),
    .pop     (pop),
    .po_prt  (po_prt),
    .cp_read (cp_read),
    .cp_adr  (cp_adr),
    .ready   (ready),
    .full    (full),
    .po_vld  (po_vld),
    .po_dout (po_dout),
    .cp_vld  (cp_vld),
    .cp_dout (cp_dout)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_word(output logic [mq_pkg::WIDTH-1:0] w);
    for (int i = 0; i < mq_pkg::WIDTH; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[mq_pkg::WIDTH-2:0], lfsr[0]};
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic tick();
    @(posedge clk);
    cyc++;
  endtask

  task automatic add_row(input int pu, input int pq, input int po, input int oq,
                         input int ok, input int cr, input int cq, input int cc);
    row_t r;
    r.push = pu[0];
    r.pu_prt = pq[mq_pkg::BITQ-1:0];
    r.pop = po[0];
    r.po_prt = oq[mq_pkg::BITQ-1:0];
    r.po_ok = ok[0];
    r.cp_read = cr[0];
    r.cp_adr = cq[mq_pkg::BITQ-1:0];
    r.cp_cnt = cc[mq_pkg::BITCNT-1:0];
    table_q.push_back(r);
  endtask

  task automatic build_table();
    add_row(1, 0, 1, 1, 0, 1, 0, 0);  // Pop of an empty queue
    add_row(1, 1, 0, 0, 0, 1, 0, 1);
    add_row(1, 0, 1, 1, 1, 1, 1, 1);  // Push to one queue and pop from another
    add_row(1, 2, 1, 0, 1, 1, 0, 2);
    add_row(1, 3, 1, 3, 0, 1, 3, 0);  // Push wins over a pop of the same empty queue
    add_row(0, 0, 1, 3, 1, 1, 3, 1);
    add_row(0, 0, 1, 3, 0, 1, 3, 0);
    add_row(1, 2, 1, 2, 1, 1, 2, 1);  // Last entry handed to a new push
    add_row(0, 0, 1, 0, 1, 1, 0, 1);
    add_row(0, 0, 1, 2, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 1, 2, 0);
    for (int i = 0; i < mq_pkg::NUMADDR; i++) begin
      add_row(1, i % 4, 0, 0, 0, 1, i % 4, i / 4);
    end
    add_row(1, 1, 0, 0, 0, 1, 1, 4);  // Dropped while the buffer is full
    for (int i = 0; i < mq_pkg::NUMADDR; i++) begin
      add_row(0, 0, 1, i % 4, 1, 1, i % 4, 4 - i / 4);
    end
    add_row(0, 0, 1, 0, 0, 1, 1, 0);
    for (int i = 0; i < mq_pkg::NUMADDR; i++) begin
      add_row(1, 3, 0, 0, 0, 1, 3, i);
    end
    // First push here meets a full buffer
    for (int i = 0; i < mq_pkg::NUMADDR; i++) begin
      add_row(1, 0, 1, 3, 1, 1, 3, 16 - i);
    end
    for (int i = 0; i < mq_pkg::NUMADDR - 1; i++) begin
      add_row(0, 0, 1, 0, 1, 1, 0, 15 - i);
    end
  endtask

  task automatic check_outputs();
    logic exp_po;
    logic exp_cp;
    exp_po = 1'b0;
    exp_cp = 1'b0;
    if (po_due.size() > 0) begin
      exp_po = (po_due[0] == cyc);
    end
    if (cp_due.size() > 0) begin
      exp_cp = (cp_due[0] == cyc);
    end
    assert (ready) else stop_with_error("ready dropped after initialization");
    assert (full == (model_total == mq_pkg::NUMADDR))
      else stop_with_error($sformatf("error full: got %h expected %h", full,
                                     model_total == mq_pkg::NUMADDR));
    assert (po_vld == exp_po)
      else stop_with_error($sformatf("error po_vld: got %h expected %h", po_vld, exp_po));
    if (exp_po) begin
      assert (po_dout == po_exp[0])
        else stop_with_error($sformatf("error po_dout: got %h expected %h",
                                       po_dout, po_exp[0]));
      void'(po_due.pop_front());
      void'(po_exp.pop_front());
    end
    assert (cp_vld == exp_cp)
      else stop_with_error($sformatf("error cp_vld: got %h expected %h", cp_vld, exp_cp));
    if (exp_cp) begin
      assert (int'(cp_dout) == cp_exp[0])
        else stop_with_error($sformatf("error cp_dout: got %h expected %h",
                                       cp_dout, cp_exp[0]));
      void'(cp_due.pop_front());
      void'(cp_exp.pop_front());
    end
  endtask

  // Edge e takes the row; counts are those before e
  task automatic predict_row(input row_t r, input logic [mq_pkg::WIDTH-1:0] w, input int e);
    logic pu_acc;
    logic po_acc;
    int   q;
    pu_acc = r.push && (model_total < mq_pkg::NUMADDR);
    po_acc = r.pop && (model_cnt[int'(r.po_prt)] != 0);
    if (r.cp_read) begin
      assert (int'(r.cp_cnt) == model_cnt[int'(r.cp_adr)])
        else stop_with_error("stimulus table count disagrees with the reference queues");
      cp_due.push_back(e + 1);
      cp_exp.push_back(int'(r.cp_cnt));
    end
    assert (po_acc == r.po_ok)
      else stop_with_error("stimulus table pop prediction disagrees with the reference queues");
    if (po_acc) begin
      q = int'(r.po_prt);
      po_due.push_back(e + 2);
      po_exp.push_back(model_mem[q][model_rd[q]]);
      model_rd[q] = (model_rd[q] + 1) % mq_pkg::NUMADDR;
      model_cnt[q]--;
      model_total--;
    end
    if (pu_acc) begin
      q = int'(r.pu_prt);
      model_mem[q][(model_rd[q] + model_cnt[q]) % mq_pkg::NUMADDR] = w;
      model_cnt[q]++;
      model_total++;
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [mq_pkg::WIDTH-1:0] w;
    next_word(w);
    tick();
    push <= r.push;
    pu_prt <= r.pu_prt;
    pu_din <= w;
    pop <= r.pop;
    po_prt <= r.po_prt;
    cp_read <= r.cp_read;
    cp_adr <= r.cp_adr;
    @(negedge clk);  // Outputs settled for edge cyc
    check_outputs();
    predict_row(r, w, cyc + 1);
  endtask

  initial begin
    int wait_cnt;
    rst <= 1'b1;
    push <= 1'b0;
    pu_prt <= '0;
    pu_din <= '0;
    pop <= 1'b0;
    po_prt <= '0;
    cp_read <= 1'b0;
    cp_adr <= '0;
    lfsr = 16'd28165;
    cyc = 0;
    model_total = 0;
    for (int i = 0; i < mq_pkg::NUMQ; i++) begin
      model_rd[i] = 0;
      model_cnt[i] = 0;
    end
    build_table();
    repeat (4) tick();
    rst <= 1'b0;
    wait_cnt = 0;
    do begin
      tick();
      @(negedge clk);
      assert (!full && !po_vld && !cp_vld)
        else stop_with_error("full or an output strobe was high during initialization");
      wait_cnt++;
      if (wait_cnt > 100) begin
        stop_with_error("timeout waiting for ready after reset");
      end
    end while (!ready);
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    wait_cnt = 0;
    while (po_due.size() > 0 || cp_due.size() > 0) begin
      apply_row('0);
      wait_cnt++;
      if (wait_cnt > 10) begin
        stop_with_error("timeout waiting for pending pop data and count reads");
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- project.f
rtl/mq_pkg.sv
rtl/mq_mem_if.sv
rtl/mq_free_list.sv
rtl/mq_queue_ctrl.sv
rtl/mq_data_stage.sv
rtl/mq_top.sv
test/mq_assertions.sv
test/mq_tb.sv

//--- Makefile
TOP = mq_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
